// File: Bender.yml
package:
  name: bpred

sources:
  - rtl/bpred_pkg.sv
  - rtl/bpred_btb.sv
  - rtl/bpred_gshare.sv
  - rtl/bpred_pht_arbiter.sv
  - rtl/bpred_upd_queue.sv
  - rtl/bpred_predictor.sv
  - target: test
    files:
      - test/tb_bpred.sv

// File: rtl/bpred_btb.sv
/*
 * Branch target buffer
 * Direct-mapped table of valid, tag, target and kind with a one-cycle lookup
 */
`timescale 1ns/1ns

module bpred_btb #(
  parameter int BTB_ENTRIES = 16
) (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  // Stage 0 lookup
  input  logic                          i_s0_valid,
  input  logic [bpred_pkg::VADDR_W-1:0] i_s0_pc,
  // Committed branch write
  input  logic                          i_wr,
  input  logic [bpred_pkg::VADDR_W-1:0] i_wr_pc,
  input  logic                          i_wr_taken,
  input  logic [bpred_pkg::VADDR_W-1:0] i_wr_target,
  input  bpred_pkg::upd_kind_e          i_wr_kind,
  // Stage 1 result
  output logic                          o_s1_valid,
  output logic                          o_s1_hit,
  output logic [bpred_pkg::VADDR_W-1:0] o_s1_target,
  output bpred_pkg::upd_kind_e          o_s1_kind
);
  import bpred_pkg::*;

  localparam int IDX_W = $clog2(BTB_ENTRIES);
  // Address bits above the index
  localparam int TAG_W = VADDR_W - PC_LSB - IDX_W;

  // --------------------------------------------------
  // Entry storage
  // --------------------------------------------------
  logic [BTB_ENTRIES-1:0] r_valid;
  logic [TAG_W-1:0]       r_tag    [BTB_ENTRIES];
  logic [VADDR_W-1:0]     r_target [BTB_ENTRIES];
  upd_kind_e              r_kind   [BTB_ENTRIES];

  logic [IDX_W-1:0] w_s0_idx;
  logic [TAG_W-1:0] w_s0_tag;
  logic [IDX_W-1:0] w_wr_idx;
  logic [TAG_W-1:0] w_wr_tag;
  logic             w_wr_en;
  logic             w_s0_hit;

  // Index and tag split of both addresses
  assign w_s0_idx = i_s0_pc[PC_LSB +: IDX_W];
  assign w_s0_tag = i_s0_pc[VADDR_W-1 -: TAG_W];
  assign w_wr_idx = i_wr_pc[PC_LSB +: IDX_W];
  assign w_wr_tag = i_wr_pc[VADDR_W-1 -: TAG_W];

  // Jumps always allocate, conditionals only when taken
  // Not-taken branch leaves the old entry alone
  assign w_wr_en = i_wr &&
                   ((i_wr_kind == UPD_JUMP) ||
                    ((i_wr_kind == UPD_COND) && i_wr_taken));

  // Valid bits, cleared at reset
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_valid <= '0;
    end else if (w_wr_en) begin
      r_valid[w_wr_idx] <= 1'b1;
    end
  end

  // Payload, overwritten on allocation
  always_ff @(posedge i_clk) begin
    if (w_wr_en) begin
      r_tag[w_wr_idx]    <= w_wr_tag;
      r_target[w_wr_idx] <= i_wr_target;
      r_kind[w_wr_idx]   <= i_wr_kind;
    end
  end

  // --------------------------------------------------
  // Lookup, registered into stage 1
  // --------------------------------------------------

  // Hit needs valid entry and matching tag
  assign w_s0_hit = i_s0_valid && r_valid[w_s0_idx] && (r_tag[w_s0_idx] == w_s0_tag);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_s1_valid <= 1'b0;
      o_s1_hit   <= 1'b0;
    end else begin
      o_s1_valid <= i_s0_valid;
      o_s1_hit   <= w_s0_hit;
    end
  end

  // Target and kind only meaningful with o_s1_hit
  always_ff @(posedge i_clk) begin
    o_s1_target <= r_target[w_s0_idx];
    o_s1_kind   <= r_kind[w_s0_idx];
  end

endmodule

// File: rtl/bpred_gshare.sv
/*
 * Gshare direction logic
 * Commit-time global history, PHT index hashing and the stage 2 decision
 */
`timescale 1ns/1ns

module bpred_gshare #(
  parameter int PHT_ENTRIES = 64
) (
  input  logic                              i_clk,
  input  logic                              i_rst_n,
  // Addresses to hash
  input  logic [bpred_pkg::VADDR_W-1:0]     i_s0_pc,
  input  logic [bpred_pkg::VADDR_W-1:0]     i_upd_pc,
  // Queue head being retired
  input  logic                              i_pop,
  input  bpred_pkg::upd_kind_e              i_upd_kind,
  input  logic                              i_upd_taken,
  // Stage 1 inputs from the BTB and the arbiter
  input  logic                              i_s1_valid,
  input  logic [bpred_pkg::CNT_W-1:0]       i_s1_cnt,
  input  logic                              i_s1_btb_hit,
  input  bpred_pkg::upd_kind_e              i_s1_btb_kind,
  input  logic [bpred_pkg::VADDR_W-1:0]     i_s1_btb_target,
  // PHT indices
  output logic [$clog2(PHT_ENTRIES)-1:0]    o_search_idx,
  output logic [$clog2(PHT_ENTRIES)-1:0]    o_upd_idx,
  // Stage 2 prediction
  output logic                              o_s2_predict_valid,
  output logic [bpred_pkg::VADDR_W-1:0]     o_s2_predict_target
);
  import bpred_pkg::*;

  // History as long as the PHT index
  // Needs at least 4 entries for the shift below
  localparam int HIST_W = $clog2(PHT_ENTRIES);

  logic [HIST_W-1:0] r_ghist;
  logic              w_hist_upd;
  logic              w_s1_taken;
  logic              w_s1_predict;

  // --------------------------------------------------
  // Global history
  // --------------------------------------------------

  // Only conditional branches shift in their outcome
  // Updated at commit, so no repair is ever needed
  assign w_hist_upd = i_pop && (i_upd_kind == UPD_COND);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_ghist <= '0;
    end else if (w_hist_upd) begin
      // Newest outcome in bit 0
      r_ghist <= {r_ghist[HIST_W-2:0], i_upd_taken};
    end
  end

  // --------------------------------------------------
  // Index hashing
  // --------------------------------------------------

  // PC bits above the byte offset XOR history
  assign o_search_idx = i_s0_pc[PC_LSB +: HIST_W] ^ r_ghist;

  // Update sees history before its own shift
  assign o_upd_idx = i_upd_pc[PC_LSB +: HIST_W] ^ r_ghist;

  // --------------------------------------------------
  // Stage 2 decision
  // --------------------------------------------------

  // Direction from the entry kind and the counter
  always_comb begin
    w_s1_taken = 1'b0;
    case (i_s1_btb_kind)
      UPD_JUMP: w_s1_taken = 1'b1;
      UPD_COND: w_s1_taken = (i_s1_cnt >= CNT_TAKEN_MIN);
      default:  w_s1_taken = 1'b0;
    endcase
  end

  // No target without a BTB hit
  assign w_s1_predict = i_s1_valid && i_s1_btb_hit && w_s1_taken;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_s2_predict_valid <= 1'b0;
    end else begin
      o_s2_predict_valid <= w_s1_predict;
    end
  end

  // Target follows the BTB entry
  always_ff @(posedge i_clk) begin
    o_s2_predict_target <= i_s1_btb_target;
  end

endmodule

// File: rtl/bpred_pht_arbiter.sv
/*
 * PHT array and port arbiter
 * Single-port counter table shared by lookups (priority) and queued updates
 */
`timescale 1ns/1ns

module bpred_pht_arbiter #(
  parameter int PHT_ENTRIES = 64
) (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  // Lookup request
  input  logic                           i_s0_valid,
  input  logic [$clog2(PHT_ENTRIES)-1:0] i_search_idx,
  // Queue head
  input  logic                           i_q_empty,
  input  bpred_pkg::upd_kind_e           i_upd_kind,
  input  logic [$clog2(PHT_ENTRIES)-1:0] i_upd_idx,
  input  logic                           i_upd_taken,
  output logic                           o_pop,
  output logic [bpred_pkg::CNT_W-1:0]    o_s1_cnt,
  output bpred_pkg::grant_e              o_grant
);
  import bpred_pkg::*;

  localparam int               IDX_W   = $clog2(PHT_ENTRIES);
  localparam logic [CNT_W-1:0] CNT_MAX = '1;

  logic [CNT_W-1:0] r_pht [PHT_ENTRIES];
  logic [IDX_W-1:0] w_idx;
  logic [CNT_W-1:0] w_rd_cnt;
  logic [CNT_W-1:0] w_wr_cnt;
  logic             w_wr_en;

  // --------------------------------------------------
  // Grant, lookup first
  // --------------------------------------------------
  always_comb begin
    if (i_s0_valid) begin
      o_grant = GNT_SEARCH;
    end else if (!i_q_empty) begin
      o_grant = GNT_UPDATE;
    end else begin
      o_grant = GNT_IDLE;
    end
  end

  // Every update grant retires the head
  assign o_pop = (o_grant == GNT_UPDATE);

  // One address for the single port
  assign w_idx    = o_pop ? i_upd_idx : i_search_idx;
  assign w_rd_cnt = r_pht[w_idx];

  // Saturating step, 0 and CNT_MAX are sticky
  always_comb begin
    w_wr_cnt = w_rd_cnt;
    if (i_upd_taken) begin
      if (w_rd_cnt != CNT_MAX) begin
        w_wr_cnt = w_rd_cnt + CNT_W'(1);
      end
    end else if (w_rd_cnt != '0) begin
      w_wr_cnt = w_rd_cnt - CNT_W'(1);
    end
  end

  // Jumps pop without touching counters
  assign w_wr_en = o_pop && (i_upd_kind == UPD_COND);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < PHT_ENTRIES; i++) begin
        r_pht[i] <= CNT_RESET;
      end
    end else if (w_wr_en) begin
      r_pht[w_idx] <= w_wr_cnt;
    end
  end

  // Lookup counter into stage 1
  always_ff @(posedge i_clk) begin
    if (o_grant == GNT_SEARCH) begin
      o_s1_cnt <= w_rd_cnt;
    end
  end

  // Search and update never share the port in a cycle
  a_port_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_s0_valid |-> !w_wr_en);

endmodule

// File: rtl/bpred_pkg.sv
/*
 * Branch predictor shared definitions
 * Address layout, update and grant encodings, counter constants
 */
package bpred_pkg;

  // --------------------------------------------------
  // Address layout
  // --------------------------------------------------

  // Instruction address width
  localparam int VADDR_W = 32;

  // Low address bits dropped before any indexing
  // Fixed 4-byte instructions
  localparam int PC_LSB = 2;

  // --------------------------------------------------
  // Update opcodes
  // --------------------------------------------------

  // Kind of a committed branch, also kept in each BTB entry
  typedef enum logic [1:0] {
    // No effect on either table
    UPD_NONE = 2'd0,
    // Conditional branch, trains the PHT
    UPD_COND = 2'd1,
    // Unconditional jump, always taken
    UPD_JUMP = 2'd2
  } upd_kind_e;

  // --------------------------------------------------
  // PHT arbiter grant
  // --------------------------------------------------

  // Single user of the PHT array in a cycle
  typedef enum logic [1:0] {
    GNT_IDLE   = 2'd0,
    // Fetch lookup reads a counter
    GNT_SEARCH = 2'd1,
    // Queued update does a read-modify-write
    GNT_UPDATE = 2'd2
  } grant_e;

  // --------------------------------------------------
  // Saturating counters
  // --------------------------------------------------

  // Counter width, 0..3
  localparam int CNT_W = 2;

  // Weakly not taken after reset
  localparam logic [CNT_W-1:0] CNT_RESET = CNT_W'(1);

  // Weakly taken and above predict taken
  localparam logic [CNT_W-1:0] CNT_TAKEN_MIN = CNT_W'(2);

endpackage

// File: rtl/bpred_predictor.sv
/*
 * Branch predictor top
 * BTB hit and target at s1, gshare direction at s2, credit-based update port
 */
`timescale 1ns/1ns

module bpred_predictor #(
  parameter int BTB_ENTRIES = 16,
  parameter int PHT_ENTRIES = 64,
  parameter int UPD_DEPTH   = 4
) (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  // Fetch lookup
  input  logic                          i_s0_valid,
  input  logic [bpred_pkg::VADDR_W-1:0] i_s0_pc,
  // Commit updates
  input  logic                          i_upd_valid,
  input  bpred_pkg::upd_kind_e          i_upd_kind,
  input  logic [bpred_pkg::VADDR_W-1:0] i_upd_pc,
  input  logic                          i_upd_taken,
  input  logic [bpred_pkg::VADDR_W-1:0] i_upd_target,
  // Feedback into fetch
  output logic                          o_s1_btb_hit,
  output logic [bpred_pkg::VADDR_W-1:0] o_s1_btb_target,
  output logic                          o_s2_predict_valid,
  output logic [bpred_pkg::VADDR_W-1:0] o_s2_predict_target,
  output logic                          o_upd_credit
);
  import bpred_pkg::*;

  localparam int PHT_IDX_W = $clog2(PHT_ENTRIES);

  // Queue head
  logic               w_q_empty;
  upd_kind_e          w_head_kind;
  logic [VADDR_W-1:0] w_head_pc;
  logic               w_head_taken;
  logic [VADDR_W-1:0] w_head_target;
  logic               w_pop;
  // Stage 1 path
  logic               w_s1_valid;
  upd_kind_e          w_s1_kind;
  logic [CNT_W-1:0]   w_s1_cnt;
  logic [PHT_IDX_W-1:0] w_search_idx;
  logic [PHT_IDX_W-1:0] w_upd_idx;

  // --------------------------------------------------
  // Update queue
  // --------------------------------------------------
  bpred_upd_queue #(.UPD_DEPTH(UPD_DEPTH)) u_upd_queue (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_upd_valid(i_upd_valid), .i_upd_kind(i_upd_kind), .i_upd_pc(i_upd_pc),
    .i_upd_taken(i_upd_taken), .i_upd_target(i_upd_target),
    .i_pop(w_pop), .o_empty(w_q_empty),
    .o_head_kind(w_head_kind), .o_head_pc(w_head_pc),
    .o_head_taken(w_head_taken), .o_head_target(w_head_target),
    .o_credit(o_upd_credit)
  );

  // --------------------------------------------------
  // BTB, written by the popped head
  // --------------------------------------------------
  bpred_btb #(.BTB_ENTRIES(BTB_ENTRIES)) u_btb (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_s0_valid(i_s0_valid), .i_s0_pc(i_s0_pc),
    .i_wr(w_pop), .i_wr_pc(w_head_pc), .i_wr_taken(w_head_taken),
    .i_wr_target(w_head_target), .i_wr_kind(w_head_kind),
    .o_s1_valid(w_s1_valid), .o_s1_hit(o_s1_btb_hit),
    .o_s1_target(o_s1_btb_target), .o_s1_kind(w_s1_kind)
  );

  // --------------------------------------------------
  // PHT and its arbiter, grant left for debug probing
  // --------------------------------------------------
  bpred_pht_arbiter #(.PHT_ENTRIES(PHT_ENTRIES)) u_arb (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_s0_valid(i_s0_valid), .i_search_idx(w_search_idx),
    .i_q_empty(w_q_empty), .i_upd_kind(w_head_kind),
    .i_upd_idx(w_upd_idx), .i_upd_taken(w_head_taken),
    .o_pop(w_pop), .o_s1_cnt(w_s1_cnt), .o_grant()
  );

  // Gshare history and stage 2
  bpred_gshare #(.PHT_ENTRIES(PHT_ENTRIES)) u_gshare (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_s0_pc(i_s0_pc), .i_upd_pc(w_head_pc),
    .i_pop(w_pop), .i_upd_kind(w_head_kind), .i_upd_taken(w_head_taken),
    .i_s1_valid(w_s1_valid), .i_s1_cnt(w_s1_cnt),
    .i_s1_btb_hit(o_s1_btb_hit), .i_s1_btb_kind(w_s1_kind),
    .i_s1_btb_target(o_s1_btb_target),
    .o_search_idx(w_search_idx), .o_upd_idx(w_upd_idx),
    .o_s2_predict_valid(o_s2_predict_valid),
    .o_s2_predict_target(o_s2_predict_target)
  );

endmodule

// File: rtl/bpred_upd_queue.sv
/*
 * Branch update queue
 * Credit-based FIFO holding committed branches until the PHT arbiter takes them
 */
`timescale 1ns/1ns

module bpred_upd_queue #(
  parameter int UPD_DEPTH = 4
) (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  // Commit side push, only with a credit held
  input  logic                          i_upd_valid,
  input  bpred_pkg::upd_kind_e          i_upd_kind,
  input  logic [bpred_pkg::VADDR_W-1:0] i_upd_pc,
  input  logic                          i_upd_taken,
  input  logic [bpred_pkg::VADDR_W-1:0] i_upd_target,
  // Arbiter side
  input  logic                          i_pop,
  output logic                          o_empty,
  output bpred_pkg::upd_kind_e          o_head_kind,
  output logic [bpred_pkg::VADDR_W-1:0] o_head_pc,
  output logic                          o_head_taken,
  output logic [bpred_pkg::VADDR_W-1:0] o_head_target,
  // One credit back per pop
  output logic                          o_credit
);
  import bpred_pkg::*;

  localparam int               PTR_W    = (UPD_DEPTH > 1) ? $clog2(UPD_DEPTH) : 1;
  localparam int               CNT_QW   = $clog2(UPD_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(UPD_DEPTH - 1);

  upd_kind_e          r_kind   [UPD_DEPTH];
  logic [VADDR_W-1:0] r_pc     [UPD_DEPTH];
  logic               r_taken  [UPD_DEPTH];
  logic [VADDR_W-1:0] r_target [UPD_DEPTH];
  logic [PTR_W-1:0]   r_wr_ptr;
  logic [PTR_W-1:0]   r_rd_ptr;
  logic [CNT_QW-1:0]  r_count;

  // Entry storage
  always_ff @(posedge i_clk) begin
    if (i_upd_valid) begin
      r_kind[r_wr_ptr]   <= i_upd_kind;
      r_pc[r_wr_ptr]     <= i_upd_pc;
      r_taken[r_wr_ptr]  <= i_upd_taken;
      r_target[r_wr_ptr] <= i_upd_target;
    end
  end

  // Pointers wrap at the last slot, depth need not be a power of two
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
      o_credit <= 1'b0;
    end else begin
      if (i_upd_valid) begin
        r_wr_ptr <= (r_wr_ptr == LAST_PTR) ? '0 : r_wr_ptr + PTR_W'(1);
      end
      if (i_pop) begin
        r_rd_ptr <= (r_rd_ptr == LAST_PTR) ? '0 : r_rd_ptr + PTR_W'(1);
      end
      case ({i_upd_valid, i_pop})
        2'b10:   r_count <= r_count + CNT_QW'(1);
        2'b01:   r_count <= r_count - CNT_QW'(1);
        default: r_count <= r_count;
      endcase
      // Credit pulse the cycle after the pop
      o_credit <= i_pop;
    end
  end

  assign o_empty       = (r_count == '0);
  assign o_head_kind   = r_kind[r_rd_ptr];
  assign o_head_pc     = r_pc[r_rd_ptr];
  assign o_head_taken  = r_taken[r_rd_ptr];
  assign o_head_target = r_target[r_rd_ptr];

  // Push into a full queue means the sender ignored its credits
  a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_upd_valid |-> (r_count != CNT_QW'(UPD_DEPTH)));
  a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_pop |-> !o_empty);

endmodule

// File: test/bpred_input.txt
# cmd kind pc taken target | exp_hit exp_target exp_pred (hex, kind 1 cond 2 jump)
# FILL pc=1 starts a random lookup stream, pc=0 stops it
LOOK  0 00001000 0 00000000 0 00000000 0
UPD   2 00000040 1 00000400 0 00000000 0
DRAIN 0 00000000 0 00000000 0 00000000 0
LOOK  0 00000040 0 00000000 1 00000400 1
UPD   1 00000104 1 00000200 0 00000000 0
UPD   1 00000104 1 00000200 0 00000000 0
UPD   1 00000104 1 00000200 0 00000000 0
UPD   1 00000104 1 00000200 0 00000000 0
UPD   1 00000104 1 00000200 0 00000000 0
DRAIN 0 00000000 0 00000000 0 00000000 0
LOOK  0 00000104 0 00000000 1 00000200 1
UPD   1 00000104 0 00000200 0 00000000 0
UPD   1 00000104 0 00000200 0 00000000 0
UPD   1 00000104 0 00000200 0 00000000 0
UPD   1 00000104 0 00000200 0 00000000 0
UPD   1 00000104 0 00000200 0 00000000 0
DRAIN 0 00000000 0 00000000 0 00000000 0
LOOK  0 00000104 0 00000000 1 00000200 0
UPD   1 00000124 1 00000300 0 00000000 0
DRAIN 0 00000000 0 00000000 0 00000000 0
LOOK  0 00000124 0 00000000 1 00000300 1
LOOK  0 00000104 0 00000000 1 00000200 1
LOOK  0 00000040 0 00000000 1 00000400 1
LOOK  0 00001000 0 00000000 0 00000000 0
FILL  0 00000001 0 00000000 0 00000000 0
UPD   1 00000104 1 00000200 0 00000000 0
UPD   1 00000104 1 00000200 0 00000000 0
UPD   2 00000008 1 00000500 0 00000000 0
UPD   1 00000124 0 00000300 0 00000000 0
FILL  0 00000000 0 00000000 0 00000000 0
DRAIN 0 00000000 0 00000000 0 00000000 0
LOOK  0 00000008 0 00000000 1 00000500 1
LOOK  0 00000124 0 00000000 1 00000300 0
LOOK  0 00000104 0 00000000 1 00000200 0

// File: test/tb_bpred.sv
/*
 * Branch predictor testbench
 * Replays the command file, models BTB, counters and history, checks s1, s2 and credits
 */
`timescale 1ns/1ns

module tb_bpred;
  import bpred_pkg::*;

  // Small PHT keeps the history short enough to steer by hand
  localparam int BTB_N   = 16;
  localparam int PHT_N   = 4;
  localparam int DEPTH   = 4;
  localparam int MAX_LN  = 64;
  localparam int C_UPD   = 0;
  localparam int C_LOOK  = 1;
  localparam int C_DRAIN = 2;
  localparam int C_FILL  = 3;

  logic               i_clk;
  logic               i_rst_n;
  logic               i_s0_valid;
  logic [VADDR_W-1:0] i_s0_pc;
  logic               i_upd_valid;
  upd_kind_e          i_upd_kind;
  logic [VADDR_W-1:0] i_upd_pc;
  logic               i_upd_taken;
  logic [VADDR_W-1:0] i_upd_target;
  logic               o_s1_btb_hit;
  logic [VADDR_W-1:0] o_s1_btb_target;
  logic               o_s2_predict_valid;
  logic [VADDR_W-1:0] o_s2_predict_target;
  logic               o_upd_credit;

  // Parsed command file
  int          nlines;
  int          l_cmd  [MAX_LN];
  logic [1:0]  l_kind [MAX_LN];
  logic [31:0] l_pc   [MAX_LN];
  logic        l_tkn  [MAX_LN];
  logic [31:0] l_tgt  [MAX_LN];
  logic        l_hit  [MAX_LN];
  logic [31:0] l_etgt [MAX_LN];
  logic        l_pred [MAX_LN];

  // Reference tables
  logic        m_valid [BTB_N];
  logic [25:0] m_tag   [BTB_N];
  logic [31:0] m_tgt   [BTB_N];
  logic [1:0]  m_kind  [BTB_N];
  int          m_cnt   [PHT_N];
  logic [1:0]  m_hist;
  // Updates sent but not yet popped, in order
  logic [1:0]  q_kind [$];
  logic [31:0] q_pc   [$];
  logic        q_tkn  [$];
  logic [31:0] q_tgt  [$];

  // File expectation travelling with a lookup
  logic        drv_has_exp;
  logic        drv_exp_hit;
  logic [31:0] drv_exp_tgt;
  logic        drv_exp_pred;

  // Lookup pipeline of expected results
  logic        st1_v;
  logic        st1_hit;
  logic        st1_pred;
  logic        st2_v;
  logic        st2_pred;
  logic [31:0] st1_tgt;
  logic [31:0] st2_tgt;

  int          credits;
  int          err_val;
  int          err_proto;
  logic        stream_on;
  logic [31:0] lfsr_state;

  bpred_predictor #(
    .BTB_ENTRIES(BTB_N), .PHT_ENTRIES(PHT_N), .UPD_DEPTH(DEPTH)
  ) UUT (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_s0_valid(i_s0_valid), .i_s0_pc(i_s0_pc),
    .i_upd_valid(i_upd_valid), .i_upd_kind(i_upd_kind), .i_upd_pc(i_upd_pc),
    .i_upd_taken(i_upd_taken), .i_upd_target(i_upd_target),
    .o_s1_btb_hit(o_s1_btb_hit), .o_s1_btb_target(o_s1_btb_target),
    .o_s2_predict_valid(o_s2_predict_valid),
    .o_s2_predict_target(o_s2_predict_target), .o_upd_credit(o_upd_credit)
  );

  always #10 i_clk = ~i_clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Word-aligned random fetch address, one step per bit
  task automatic random_pc(output logic [31:0] pc);
    pc = '0;
    for (int b = 0; b < 30; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      pc = {pc[30:0], lfsr_state[0]};
    end
    pc = {pc[29:0], 2'b00};
  endtask

  task automatic value_error(input string msg);
    err_val++;
    $display("[ERROR] %0t ns: %s", $time, msg);
  endtask

  // --------------------------------------------------
  // Default drive for a cycle
  // --------------------------------------------------
  task automatic drive_idle();
    logic [31:0] rpc;
    i_upd_valid <= 1'b0;
    drv_has_exp <= 1'b0;
    if (stream_on) begin
      random_pc(rpc);
      i_s0_valid <= 1'b1;
      i_s0_pc    <= rpc;
    end else begin
      i_s0_valid <= 1'b0;
    end
  endtask

  // Popped update trains the model, same rules as commit
  task automatic retire_update();
    logic [1:0]  k;
    logic [31:0] pc;
    logic        t;
    logic [31:0] tg;
    int          idx;
    k   = q_kind.pop_front();
    pc  = q_pc.pop_front();
    t   = q_tkn.pop_front();
    tg  = q_tgt.pop_front();
    idx = pc[3:2] ^ m_hist;
    if (k == 2'd1) begin
      if (t && m_cnt[idx] < 3) begin
        m_cnt[idx]++;
      end else if (!t && m_cnt[idx] > 0) begin
        m_cnt[idx]--;
      end
      m_hist = {m_hist[0], t};
    end
    if (k == 2'd2 || (k == 2'd1 && t)) begin
      m_valid[pc[5:2]] = 1'b1;
      m_tag[pc[5:2]]   = pc[31:6];
      m_tgt[pc[5:2]]   = tg;
      m_kind[pc[5:2]]  = k;
    end
  endtask

  // --------------------------------------------------
  // Checker, samples mid-cycle
  // --------------------------------------------------
  always @(negedge i_clk) begin
    logic hit;
    logic pred;
    int   e;
    if (!i_rst_n) begin
      st1_v = 1'b0;
      st2_v = 1'b0;
    end else begin
      if (o_upd_credit) begin
        credits++;
        if (stream_on) begin
          err_proto++;
          $display("A credit came back while lookups were still streaming");
        end
        if (q_pc.size() == 0) begin
          err_proto++;
          $display("A credit came back with no update outstanding");
        end else begin
          retire_update();
        end
      end
      // Stage 2
      if (o_s2_predict_valid !== (st2_v && st2_pred)) begin
        value_error($sformatf("s2 predict %b, expected %b", o_s2_predict_valid,
                              st2_v && st2_pred));
      end else if (st2_v && st2_pred && o_s2_predict_target !== st2_tgt) begin
        value_error($sformatf("s2 target %h, expected %h", o_s2_predict_target, st2_tgt));
      end
      // Stage 1
      if (o_s1_btb_hit !== (st1_v && st1_hit)) begin
        value_error($sformatf("s1 hit %b, expected %b", o_s1_btb_hit, st1_v && st1_hit));
      end else if (st1_v && st1_hit && o_s1_btb_target !== st1_tgt) begin
        value_error($sformatf("s1 target %h, expected %h", o_s1_btb_target, st1_tgt));
      end
      st2_v    = st1_v;
      st2_pred = st1_pred;
      st2_tgt  = st1_tgt;
      // New lookup in cycle 0
      e    = i_s0_pc[5:2];
      hit  = m_valid[e] && (m_tag[e] == i_s0_pc[31:6]);
      pred = hit && (m_kind[e] == 2'd2 ||
                     (m_kind[e] == 2'd1 && m_cnt[i_s0_pc[3:2] ^ m_hist] >= 2));
      st1_v    = i_s0_valid;
      st1_hit  = hit;
      st1_pred = pred;
      st1_tgt  = m_tgt[e];
      if (i_s0_valid && drv_has_exp) begin
        if (hit !== drv_exp_hit || pred !== drv_exp_pred ||
            (hit && m_tgt[e] !== drv_exp_tgt)) begin
          value_error($sformatf("file expects %b/%h/%b for pc %h, model gives %b/%h/%b",
                                drv_exp_hit, drv_exp_tgt, drv_exp_pred, i_s0_pc,
                                hit, m_tgt[e], pred));
        end
      end
    end
  end

  // Watchdog sized by the command count, armed once parsing and reset are done
  initial begin
    wait (i_rst_n === 1'b1);
    repeat (nlines * 40 + 200) @(posedge i_clk);
    $display("Timeout: the command file did not complete in time");
    $display("Simulation failed");
    $finish;
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    int    fd;
    int    r;
    string line;
    string word;
    i_clk        = 0;
    i_rst_n      = 0;
    i_s0_valid   = 0;
    i_s0_pc      = '0;
    i_upd_valid  = 0;
    i_upd_kind   = UPD_NONE;
    i_upd_pc     = '0;
    i_upd_taken  = 0;
    i_upd_target = '0;
    drv_has_exp  = 0;
    drv_exp_hit  = 0;
    drv_exp_tgt  = '0;
    drv_exp_pred = 0;
    st1_v        = 0;
    st2_v        = 0;
    stream_on    = 0;
    credits      = DEPTH;
    err_val      = 0;
    err_proto    = 0;
    nlines       = 0;
    lfsr_state = 32'h1d0f_f1dd;
    m_hist = '0;
    for (int i = 0; i < BTB_N; i++) begin
      m_valid[i] = 1'b0;
      m_tag[i]   = '0;
      m_tgt[i]   = '0;
      m_kind[i]  = 2'd0;
    end
    for (int i = 0; i < PHT_N; i++) begin
      m_cnt[i] = 1;
    end
    fd = $fopen("test/bpred_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the command file test/bpred_input.txt");
      $display("Simulation failed");
      $finish;
    end else begin
      while (!$feof(fd) && nlines < MAX_LN) begin
        r = $fgets(line, fd);
        if (r > 0 && line.len() > 1 && line.getc(0) != "#") begin
          r = $sscanf(line, "%s %h %h %h %h %h %h %h", word, l_kind[nlines],
                      l_pc[nlines], l_tkn[nlines], l_tgt[nlines], l_hit[nlines],
                      l_etgt[nlines], l_pred[nlines]);
          if (r == 8) begin
            case (word)
              "UPD":   l_cmd[nlines] = C_UPD;
              "LOOK":  l_cmd[nlines] = C_LOOK;
              "DRAIN": l_cmd[nlines] = C_DRAIN;
              default: l_cmd[nlines] = C_FILL;
            endcase
            nlines++;
          end
        end
      end
      $fclose(fd);
      repeat (3) @(posedge i_clk);
      i_rst_n <= 1'b1;
      for (int i = 0; i < nlines; i++) begin
        case (l_cmd[i])
          C_UPD: begin
            // Sender stalls without a credit
            while (credits == 0) begin
              @(posedge i_clk);
              drive_idle();
            end
            @(posedge i_clk);
            drive_idle();
            i_upd_valid  <= 1'b1;
            i_upd_kind   <= upd_kind_e'(l_kind[i]);
            i_upd_pc     <= l_pc[i];
            i_upd_taken  <= l_tkn[i];
            i_upd_target <= l_tgt[i];
            credits--;
            q_kind.push_back(l_kind[i]);
            q_pc.push_back(l_pc[i]);
            q_tkn.push_back(l_tkn[i]);
            q_tgt.push_back(l_tgt[i]);
          end
          C_LOOK: begin
            @(posedge i_clk);
            drive_idle();
            i_s0_valid   <= 1'b1;
            i_s0_pc      <= l_pc[i];
            drv_has_exp  <= 1'b1;
            drv_exp_hit  <= l_hit[i];
            drv_exp_tgt  <= l_etgt[i];
            drv_exp_pred <= l_pred[i];
          end
          C_DRAIN: begin
            stream_on = 1'b0;
            while (q_pc.size() != 0) begin
              @(posedge i_clk);
              drive_idle();
            end
          end
          default: begin
            @(posedge i_clk);
            stream_on = (l_pc[i] != 0);
            drive_idle();
          end
        endcase
      end
      stream_on = 1'b0;
      repeat (6) begin
        @(posedge i_clk);
        drive_idle();
      end
      if (credits != DEPTH) begin
        err_proto++;
        $display("Credits held at the end are %0d instead of %0d", credits, DEPTH);
      end
      $display("Checks done: %0d value errors, %0d protocol errors", err_val, err_proto);
      if (err_val + err_proto == 0) begin
        $display("Simulation passed");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

// File: vlog.f
rtl/bpred_pkg.sv
rtl/bpred_btb.sv
rtl/bpred_gshare.sv
rtl/bpred_pht_arbiter.sv
rtl/bpred_upd_queue.sv
rtl/bpred_predictor.sv
test/tb_bpred.sv
